// ==== design/rbcp_pkg.sv ====
package rbcp_pkg;

    localparam int ADDR_W    = 32;  // rbcp address width from the link
    localparam int DATA_W    = 8;   // one byte per access
    localparam int REG_IDX_W = 3;   // covers the six mapped regs

    typedef logic [ADDR_W-1:0]    rbcp_addr_t;  // host byte address
    typedef logic [DATA_W-1:0]    rbcp_data_t;  // wd / rd byte
    typedef logic [REG_IDX_W-1:0] reg_idx_t;    // decoded register slot

    // register map, one byte per address
    localparam rbcp_addr_t ADDR_VERSION = 32'd0;  // ro, fw version
    localparam rbcp_addr_t ADDR_GPIO_LO = 32'd1;  // rw, gpio_out[7:0]
    localparam rbcp_addr_t ADDR_GPIO_HI = 32'd2;  // rw, gpio_out[15:8]
    localparam rbcp_addr_t ADDR_GPIO_IN = 32'd3;  // ro, synced gpio_in
    localparam rbcp_addr_t ADDR_SCRATCH = 32'd4;  // rw, host scratch
    localparam rbcp_addr_t ADDR_LED     = 32'd5;  // rw, front panel leds

    // first address outside the map, everything above is unmapped
    localparam rbcp_addr_t NUM_REGS = 32'd6;

    localparam rbcp_data_t FW_VERSION = 8'h3A;  // bump on each release

endpackage

// ==== design/rbcp_bus_if.sv ====
`timescale 1ns/10ps

interface rbcp_bus_if;
    import rbcp_pkg::*;

    reg_idx_t   addr;    // register slot
    rbcp_data_t wdata;   // byte to write
    logic       wr;      // write pulse, 1 cycle
    logic       rd;      // read pulse, 1 cycle
    logic       mapped;  // address inside the map
    logic       valid;   // access present this cycle

    // decode side drives everything
    modport decode (
        output addr, wdata, wr, rd, mapped, valid
    );

    // execute side only listens
    modport exec (
        input addr, wdata, wr, rd, mapped, valid
    );

endinterface

// ==== design/rbcp_decode.sv ====
`timescale 1ns/10ps

module rbcp_decode (
    input  logic                 bus_clk,
    input  logic                 rst_n,
    input  logic                 rbcp_act,   // host session open
    input  logic                 rbcp_we,    // write strobe
    input  logic                 rbcp_re,    // read strobe
    input  rbcp_pkg::rbcp_addr_t rbcp_addr,
    input  rbcp_pkg::rbcp_data_t rbcp_wd,
    rbcp_bus_if.decode           bus
);
    import rbcp_pkg::*;

    logic wr_req;  // we qualified by act
    logic rd_req;  // re qualified by act
    logic any_req;
    logic in_map;  // full 32b compare so high bits count

    assign wr_req  = rbcp_act & rbcp_we;
    assign rd_req  = rbcp_act & rbcp_re;
    assign any_req = wr_req | rd_req;
    assign in_map  = (rbcp_addr < NUM_REGS);

    // strobes one cycle behind the host
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.valid <= 1'b0;
            bus.wr    <= 1'b0;
            bus.rd    <= 1'b0;
        end else begin
            bus.valid <= any_req;
            bus.wr    <= wr_req;
            bus.rd    <= rd_req;
        end
    end

    // payload only moves with a qualified strobe
    always_ff @(posedge bus_clk) begin
        if (any_req) begin
            bus.addr   <= rbcp_addr[REG_IDX_W-1:0];  // low bits pick the slot
            bus.wdata  <= rbcp_wd;
            bus.mapped <= in_map;                    // exec trusts this
        end
    end

    // host side never raises both strobes in one request
    a_no_dual_strobe: assert property (@(posedge bus_clk) disable iff (!rst_n)
        rbcp_act |-> !(rbcp_we && rbcp_re))
        else $error("rbcp_we and rbcp_re high together");

endmodule

// ==== design/gpio_exec.sv ====
`timescale 1ns/10ps

module gpio_exec (
    input  logic                 bus_clk,
    input  logic                 rst_n,
    rbcp_bus_if.exec             bus,
    input  logic [7:0]           gpio_in,   // async board inputs
    output logic [15:0]          gpio_out,
    output rbcp_pkg::rbcp_data_t led,
    output logic                 done,      // access finished, 1 cycle
    output logic                 hit,       // access was mapped
    output rbcp_pkg::rbcp_data_t rdata
);
    import rbcp_pkg::*;

    rbcp_data_t gpio_lo;       // gpio_out low byte
    rbcp_data_t gpio_hi;       // gpio_out high byte
    rbcp_data_t scratch;
    rbcp_data_t gpio_in_meta;  // sync stage 1
    rbcp_data_t gpio_in_sync;  // sync stage 2, safe to read
    rbcp_data_t rd_sel;        // byte picked by the read mux
    logic       do_wr;

    assign gpio_out = {gpio_hi, gpio_lo};
    assign do_wr    = bus.valid & bus.wr & bus.mapped;

    // 2-flop synchronizer for the input port
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_in_meta <= '0;
            gpio_in_sync <= '0;
        end else begin
            gpio_in_meta <= gpio_in;
            gpio_in_sync <= gpio_in_meta;
        end
    end

    // writable registers, ro slots ignore writes
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_lo <= '0;
            gpio_hi <= '0;
            scratch <= '0;
            led     <= '0;
        end else if (do_wr) begin
            case (rbcp_addr_t'(bus.addr))
                ADDR_GPIO_LO: gpio_lo <= bus.wdata;
                ADDR_GPIO_HI: gpio_hi <= bus.wdata;
                ADDR_SCRATCH: scratch <= bus.wdata;
                ADDR_LED:     led     <= bus.wdata;
                default:      ;  // version and gpio_in are read only
            endcase
        end
    end

    // read mux
    always_comb begin
        case (rbcp_addr_t'(bus.addr))
            ADDR_VERSION: rd_sel = FW_VERSION;
            ADDR_GPIO_LO: rd_sel = gpio_lo;
            ADDR_GPIO_HI: rd_sel = gpio_hi;
            ADDR_GPIO_IN: rd_sel = gpio_in_sync;
            ADDR_SCRATCH: rd_sel = scratch;
            ADDR_LED:     rd_sel = led;
            default:      rd_sel = '0;  // idx 6,7 never mapped
        endcase
    end

    // completion flags
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
            hit  <= 1'b0;
        end else begin
            done <= bus.valid;
            hit  <= bus.valid & bus.mapped;
        end
    end

    // read data, writes return zero
    always_ff @(posedge bus_clk) begin
        if (bus.valid) begin
            rdata <= bus.rd ? rd_sel : '0;
        end
    end

    // decode only ever hands over single-cycle accesses
    a_done_pulse: assert property (@(posedge bus_clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held high for more than one cycle");

endmodule

// ==== design/rbcp_respond.sv ====
`timescale 1ns/10ps

module rbcp_respond (
    input  logic                 bus_clk,
    input  logic                 rst_n,
    input  logic                 done,      // from exec, 1 cycle
    input  logic                 hit,       // mapped access
    input  rbcp_pkg::rbcp_data_t rdata,
    output logic                 rbcp_ack,  // to host, 1 cycle
    output rbcp_pkg::rbcp_data_t rbcp_rd
);

    logic ack_nxt;  // unmapped accesses never ack

    assign ack_nxt = done & hit;

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            rbcp_ack <= 1'b0;
        end else begin
            rbcp_ack <= ack_nxt;
        end
    end

    // held until the next ack so the host may sample late
    always_ff @(posedge bus_clk) begin
        if (ack_nxt) begin
            rbcp_rd <= rdata;
        end
    end

    // one request in flight means ack can never stretch
    a_ack_pulse: assert property (@(posedge bus_clk) disable iff (!rst_n)
        rbcp_ack |=> !rbcp_ack)
        else $error("rbcp_ack high for two cycles");

    a_rd_known: assert property (@(posedge bus_clk) disable iff (!rst_n)
        rbcp_ack |-> !$isunknown(rbcp_rd))
        else $error("rbcp_rd unknown during ack");

endmodule

// ==== design/rbcp_gpio_top.sv ====
`timescale 1ns/10ps

module rbcp_gpio_top (
    input  logic                 bus_clk,
    input  logic                 rst_n,
    // rbcp side of the network core
    input  logic                 rbcp_act,
    input  logic                 rbcp_we,
    input  logic                 rbcp_re,
    input  rbcp_pkg::rbcp_addr_t rbcp_addr,
    input  rbcp_pkg::rbcp_data_t rbcp_wd,
    output logic                 rbcp_ack,
    output rbcp_pkg::rbcp_data_t rbcp_rd,
    // board io
    input  logic [7:0]           gpio_in,
    output logic [15:0]          gpio_out,
    output rbcp_pkg::rbcp_data_t led
);

    logic                 exec_done;   // exec -> respond
    logic                 exec_hit;
    rbcp_pkg::rbcp_data_t exec_rdata;

    rbcp_bus_if bus ();  // decode -> exec

    rbcp_decode u_decode (
        .bus_clk   (bus_clk),
        .rst_n     (rst_n),
        .rbcp_act  (rbcp_act),
        .rbcp_we   (rbcp_we),
        .rbcp_re   (rbcp_re),
        .rbcp_addr (rbcp_addr),
        .rbcp_wd   (rbcp_wd),
        .bus       (bus.decode)
    );

    gpio_exec u_exec (
        .bus_clk  (bus_clk),
        .rst_n    (rst_n),
        .bus      (bus.exec),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .led      (led),
        .done     (exec_done),
        .hit      (exec_hit),
        .rdata    (exec_rdata)
    );

    rbcp_respond u_respond (
        .bus_clk  (bus_clk),
        .rst_n    (rst_n),
        .done     (exec_done),
        .hit      (exec_hit),
        .rdata    (exec_rdata),
        .rbcp_ack (rbcp_ack),
        .rbcp_rd  (rbcp_rd)
    );

endmodule

// ==== bench/tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker (
    input  logic                 bus_clk,
    input  logic                 rst_n,
    input  logic                 rbcp_act,
    input  logic                 rbcp_we,
    input  logic                 rbcp_re,
    input  rbcp_pkg::rbcp_addr_t rbcp_addr,
    input  rbcp_pkg::rbcp_data_t rbcp_wd,
    input  logic                 rbcp_ack,
    input  rbcp_pkg::rbcp_data_t rbcp_rd,
    input  logic [7:0]           gpio_in,
    input  logic [15:0]          gpio_out,
    input  rbcp_pkg::rbcp_data_t led,
    output int                   pass_count,
    output int                   fail_count,
    output int                   done_count,
    output int                   err_count    // acks outside any test
);
    import rbcp_pkg::*;

    localparam int    MAX_CASES   = 64;
    localparam int    ACK_LIMIT   = 10;
    localparam int    ACK_LATENCY = 3;   // strobe to ack in cycles
    localparam string CASE_FILE   = "bench/rbcp_cases.txt";

    logic [31:0] case_mem [0:6*MAX_CASES-1];
    int          num_cases = 0;
    int          test_errs;
    logic [15:0] model_gpio;  // expected gpio_out
    rbcp_data_t  model_led;

    task automatic load_cases();
        int i;
        for (i = 0; i < 6*MAX_CASES; i++) case_mem[i] = '1;
        $readmemh(CASE_FILE, case_mem);
        while (num_cases < MAX_CASES && case_mem[num_cases*6] !== '1) num_cases++;
    endtask

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp, act);
            test_errs = test_errs + 1;
        end
    endtask

    task automatic report_error(input int idx, input string msg);
        $display("ERROR time=%0t test %0d: %s", $time, idx, msg);
        test_errs = test_errs + 1;
    endtask

    // idle until the next strobe and flag any stray ack
    task automatic wait_strobe();
        @(negedge bus_clk);
        while (!(rbcp_we === 1'b1 || rbcp_re === 1'b1)) begin
            if (rst_n === 1'b1 && rbcp_ack === 1'b1) begin
                $display("ERROR time=%0t acknowledge with no request outstanding", $time);
                err_count = err_count + 1;
            end
            @(negedge bus_clk);
        end
    endtask

    task automatic run_check(input int idx);
        logic [31:0] op;
        rbcp_addr_t  addr;
        rbcp_data_t  wd;
        rbcp_data_t  exp_rd;
        logic        exp_ack;
        int          ack_cycle;
        int          cyc;
        string       kind;
        op        = case_mem[idx*6];
        addr      = case_mem[idx*6+1];
        wd        = case_mem[idx*6+2][7:0];
        exp_ack   = case_mem[idx*6+4][0];
        exp_rd    = case_mem[idx*6+5][7:0];
        test_errs = 0;
        ack_cycle = 0;
        cyc       = 0;
        kind      = op[0] ? "write" : "read";
        if (op[1]) kind = {kind, " act low"};
        if (rbcp_we !== op[0] || rbcp_re !== ~op[0] || rbcp_act !== ~op[1]
                || rbcp_addr !== addr || rbcp_wd !== wd
                || gpio_in !== case_mem[idx*6+3][7:0])
            report_error(idx, "stimulus on the bus does not match the case line");
        while (ack_cycle == 0 && cyc < ACK_LIMIT) begin
            @(negedge bus_clk);
            cyc = cyc + 1;
            if (rbcp_ack === 1'b1) begin
                ack_cycle = cyc;
                if (exp_ack) check_val("rbcp_rd", {8'h00, exp_rd}, {8'h00, rbcp_rd});
                if (exp_ack && !op[0] && addr == ADDR_VERSION)
                    check_val("rbcp_rd", {8'h00, FW_VERSION}, {8'h00, rbcp_rd});
            end
        end
        if (exp_ack && ack_cycle == 0)
            report_error(idx, $sformatf("no acknowledge within %0d cycles", ACK_LIMIT));
        else if (!exp_ack && ack_cycle != 0)
            report_error(idx, "acknowledge for an access that must get none");
        else if (ack_cycle != 0 && ack_cycle != ACK_LATENCY)
            report_error(idx, $sformatf("acknowledge after %0d cycles, not %0d",
                                        ack_cycle, ACK_LATENCY));
        if (op == 32'd1 && addr < NUM_REGS) begin  // only active mapped writes land
            case (addr)
                ADDR_GPIO_LO: model_gpio[7:0]  = wd;
                ADDR_GPIO_HI: model_gpio[15:8] = wd;
                ADDR_LED:     model_led        = wd;
                default:      ;
            endcase
        end
        check_val("gpio_out", model_gpio, gpio_out);
        check_val("led", {8'h00, model_led}, {8'h00, led});
        done_count = done_count + 1;
        if (test_errs == 0) begin
            pass_count = pass_count + 1;
            $display("test %0d %s addr=%h ok", idx, kind, addr);
        end else begin
            fail_count = fail_count + 1;
            $display("test %0d %s addr=%h FAILED, %0d errors", idx, kind, addr, test_errs);
        end
    endtask

    initial begin
        int idx;
        pass_count = 0;
        fail_count = 0;
        done_count = 0;
        err_count  = 0;
        model_gpio = '0;  // reset values
        model_led  = '0;
        load_cases();
        wait (rst_n === 1'b1);
        for (idx = 0; idx < num_cases; idx++) begin
            wait_strobe();
            run_check(idx);
        end
    end

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/10ps

module tb_top;
    import rbcp_pkg::*;

    localparam int    CLK_PERIOD  = 40;
    localparam int    RST_CYCLES  = 3;
    localparam int    MAX_CASES   = 64;
    localparam int    ACK_LIMIT   = 10;  // cycles to wait for ack
    localparam int    CASE_BUDGET = 25;  // watchdog cycles per case
    localparam string CASE_FILE   = "bench/rbcp_cases.txt";

    logic        bus_clk;
    logic        rst_n;
    logic        rbcp_act;
    logic        rbcp_we;
    logic        rbcp_re;
    rbcp_addr_t  rbcp_addr;
    rbcp_data_t  rbcp_wd;
    logic        rbcp_ack;
    rbcp_data_t  rbcp_rd;
    logic [7:0]  gpio_in;
    logic [15:0] gpio_out;
    rbcp_data_t  led;

    logic [31:0] case_mem [0:6*MAX_CASES-1];  // six words per case
    int          num_cases = 0;
    logic        cases_loaded = 1'b0;
    logic [31:0] rng_state;                   // idle gap generator
    int          pass_count;
    int          fail_count;
    int          done_count;
    int          err_count;

    rbcp_gpio_top u_dut (
        .bus_clk(bus_clk), .rst_n(rst_n), .rbcp_act(rbcp_act), .rbcp_we(rbcp_we),
        .rbcp_re(rbcp_re), .rbcp_addr(rbcp_addr), .rbcp_wd(rbcp_wd), .rbcp_ack(rbcp_ack),
        .rbcp_rd(rbcp_rd), .gpio_in(gpio_in), .gpio_out(gpio_out), .led(led)
    );

    tb_checker u_chk (
        .bus_clk(bus_clk), .rst_n(rst_n), .rbcp_act(rbcp_act), .rbcp_we(rbcp_we),
        .rbcp_re(rbcp_re), .rbcp_addr(rbcp_addr), .rbcp_wd(rbcp_wd), .rbcp_ack(rbcp_ack),
        .rbcp_rd(rbcp_rd), .gpio_in(gpio_in), .gpio_out(gpio_out), .led(led),
        .pass_count(pass_count), .fail_count(fail_count), .done_count(done_count),
        .err_count(err_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_cases();
        int i;
        for (i = 0; i < 6*MAX_CASES; i++) case_mem[i] = '1;  // all ones marks the end
        $readmemh(CASE_FILE, case_mem);
        while (num_cases < MAX_CASES && case_mem[num_cases*6] !== '1) num_cases++;
        cases_loaded = 1'b1;
    endtask

    // one request: input port first, idle gap, strobe, then wait for ack
    task automatic run_case(input int idx);
        logic [31:0] op;
        int          gap;
        int          waited;
        op        = case_mem[idx*6];
        rng_state = xorshift32(rng_state);
        gap       = 4 + int'(rng_state[2:0]);  // 4..11 cycles
        @(posedge bus_clk);
        #1;
        gpio_in = case_mem[idx*6+3][7:0];  // held through the gap, sync needs 3
        repeat (gap) @(posedge bus_clk);
        #1;
        rbcp_act  = ~op[1];
        rbcp_we   = op[0];
        rbcp_re   = ~op[0];
        rbcp_addr = case_mem[idx*6+1];
        rbcp_wd   = case_mem[idx*6+2][7:0];
        @(posedge bus_clk);
        #1;
        rbcp_act = 1'b0;
        rbcp_we  = 1'b0;
        rbcp_re  = 1'b0;
        waited   = 0;
        while (waited < ACK_LIMIT) begin
            @(negedge bus_clk);  // outputs settled mid cycle
            waited = waited + 1;
            if (rbcp_ack === 1'b1) break;
        end
    endtask

    initial begin
        bus_clk = 1'b0;
        forever #(CLK_PERIOD/2) bus_clk = ~bus_clk;
    end

    initial begin
        int idx;
        rst_n     = 1'b0;
        rbcp_act  = 1'b0;
        rbcp_we   = 1'b0;
        rbcp_re   = 1'b0;
        rbcp_addr = '0;
        rbcp_wd   = '0;
        gpio_in   = '0;
        rng_state = 32'd60;
        load_cases();
        repeat (RST_CYCLES) @(posedge bus_clk);
        #1;
        rst_n = 1'b1;
        for (idx = 0; idx < num_cases; idx++) run_case(idx);
        wait (done_count == num_cases);  // checker closes the last test
        $display("tests %0d, passed %0d, failed %0d, stray errors %0d",
                 num_cases, pass_count, fail_count, err_count);
        if (num_cases > 0 && fail_count == 0 && err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog, worst case gap plus ack limit stays well inside the budget
    initial begin
        wait (cases_loaded);
        repeat (num_cases * CASE_BUDGET + RST_CYCLES + 4) @(posedge bus_clk);
        $display("watchdog expired, only %0d of %0d tests finished", done_count, num_cases);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== bench/rbcp_cases.txt ====
// op addr wdata gpio_in exp_ack exp_rd, all hex
// op 0 read, 1 write, 2 read with rbcp_act low, 3 write with rbcp_act low
0 00000001 00 00 1 00  // reset state of gpio lo
0 00000002 00 00 1 00  // gpio hi
0 00000004 00 00 1 00  // scratch
0 00000005 00 00 1 00  // led
0 00000000 00 00 1 3A  // version
1 00000000 FF 00 1 00  // write to version, acked, ignored
0 00000000 00 00 1 3A
1 00000001 A5 00 1 00
1 00000002 5C 00 1 00
0 00000001 00 00 1 A5
0 00000002 00 00 1 5C
1 00000005 81 00 1 00
0 00000005 00 00 1 81
1 00000004 C3 00 1 00
0 00000004 00 00 1 C3
0 00000003 00 6B 1 6B  // input port through the synchronizer
1 00000003 12 6B 1 00  // read only
0 00000003 00 6B 1 6B
0 00000003 00 94 1 94
1 00000006 77 94 0 00  // first unmapped address
0 000000FF 00 94 0 00
1 00010002 EE 94 0 00  // high bits set, low bits alias gpio hi
0 00010002 00 94 0 00
0 00000002 00 94 1 5C  // gpio hi untouched
3 00000001 11 94 0 00  // strobe without act
2 00000004 00 94 0 00
0 00000001 00 94 1 A5
0 00000004 00 94 1 C3

// ==== compile.f ====
design/rbcp_pkg.sv
design/rbcp_bus_if.sv
design/rbcp_decode.sv
design/gpio_exec.sv
design/rbcp_respond.sv
design/rbcp_gpio_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
